// File: rv_core_pkg.sv
/* shared widths, reset pc, opcode/format/alu enums,
   instruction word views and port structs of the rv32i core */
package rv_core_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j, fmt_none
    } inst_fmt_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    // field layouts, msb first
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        opcode_e    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] funct3;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      imm;
        inst_fmt_e  fmt;
        alu_op_e    alu_op;
    } decoded_t;

    typedef struct packed {
        logic  read;
        logic  write;
        word_t addr;   // word aligned
        word_t wdata;
    } dmem_req_t;

    typedef struct packed {
        word_t    pc;
        logic     we;
        reg_idx_t rd;
        word_t    wdata;
    } retire_t;

endpackage

// File: alu.sv
/* integer alu for the rv32i arithmetic, logic, shift and compare operations */
`timescale 1ns/1ps

module alu (
    input  rv_core_pkg::alu_op_e op,
    input  rv_core_pkg::word_t   a,
    input  rv_core_pkg::word_t   b,
    output rv_core_pkg::word_t   result
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_core_pkg::alu_add:  result = a + b;
            rv_core_pkg::alu_sub:  result = a - b;
            rv_core_pkg::alu_sll:  result = a << shamt;
            rv_core_pkg::alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
            rv_core_pkg::alu_sltu: result = {31'b0, a < b};
            rv_core_pkg::alu_xor:  result = a ^ b;
            rv_core_pkg::alu_srl:  result = a >> shamt;
            rv_core_pkg::alu_sra:  result = $signed(a) >>> shamt; // keeps the sign
            rv_core_pkg::alu_or:   result = a | b;
            rv_core_pkg::alu_and:  result = a & b;
            default:               result = '0;
        endcase
    end

endmodule

// File: fetch_unit.sv
/* pc register, next-pc selection and the fetch / execute / memory sequencer */
`timescale 1ns/1ps

module fetch_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               jump_en,
    input  rv_core_pkg::word_t jump_target,
    input  logic               mem_access,
    input  rv_core_pkg::word_t imem_rdata,
    output logic               imem_req,
    output rv_core_pkg::word_t pc,
    output rv_core_pkg::word_t instr,
    output logic               exec_phase,
    output logic               retire_strobe
);
    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_memory
    } state_e;

    state_e state, next_state;
    rv_core_pkg::word_t instr_q;

    always_comb begin
        case (state)
            st_fetch:   next_state = imem_req ? st_execute : st_fetch;
            st_execute: next_state = mem_access ? st_memory : st_fetch;
            default:    next_state = st_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_fetch;
            imem_req <= 1'b0;
            pc       <= rv_core_pkg::reset_pc;
        end else begin
            state    <= next_state;
            imem_req <= (next_state == st_fetch); // one request per fetch visit
            if (retire_strobe)
                pc <= jump_en ? jump_target : pc + 32'd4;
        end
    end

    // hold the word for the memory cycle of loads and stores
    always_ff @(posedge clk) begin
        if (state == st_execute)
            instr_q <= imem_rdata;
    end

    assign exec_phase    = (state == st_execute);
    assign instr         = exec_phase ? imem_rdata : instr_q; // fresh word arrives in execute
    assign retire_strobe = (exec_phase && !mem_access) || (state == st_memory);

    a_req_only_in_fetch: assert property (
        @(posedge clk) disable iff (reset) (state != st_fetch) |-> !imem_req
    );

endmodule

// File: decode_unit.sv
/* instruction decoder: format, sign-extended immediate and alu operation */
`timescale 1ns/1ps

module decode_unit (
    input  rv_core_pkg::word_t    instr,
    output rv_core_pkg::decoded_t dec
);
    rv_core_pkg::instr_u    iw;
    rv_core_pkg::inst_fmt_e fmt;
    rv_core_pkg::word_t     imm;
    rv_core_pkg::alu_op_e   alu_op;

    assign iw = instr;

    always_comb begin
        case (iw.r.opcode)
            rv_core_pkg::opc_op:     fmt = rv_core_pkg::fmt_r;
            rv_core_pkg::opc_op_imm,
            rv_core_pkg::opc_load,
            rv_core_pkg::opc_jalr:   fmt = rv_core_pkg::fmt_i;
            rv_core_pkg::opc_store:  fmt = rv_core_pkg::fmt_s;
            rv_core_pkg::opc_branch: fmt = rv_core_pkg::fmt_b;
            rv_core_pkg::opc_lui,
            rv_core_pkg::opc_auipc:  fmt = rv_core_pkg::fmt_u;
            rv_core_pkg::opc_jal:    fmt = rv_core_pkg::fmt_j;
            default:                 fmt = rv_core_pkg::fmt_none;
        endcase
    end

    // immediate bits read through the view of the selected format
    always_comb begin
        case (fmt)
            rv_core_pkg::fmt_i: imm = {{20{iw.i.imm_11_0[11]}}, iw.i.imm_11_0};
            rv_core_pkg::fmt_s: imm = {{20{iw.s.imm_11_5[6]}}, iw.s.imm_11_5, iw.s.imm_4_0};
            rv_core_pkg::fmt_b: imm = {{19{iw.b.imm_12}}, iw.b.imm_12, iw.b.imm_11,
                                       iw.b.imm_10_5, iw.b.imm_4_1, 1'b0};
            rv_core_pkg::fmt_u: imm = {iw.u.imm_31_12, 12'h000};
            rv_core_pkg::fmt_j: imm = {{11{iw.j.imm_20}}, iw.j.imm_20, iw.j.imm_19_12,
                                       iw.j.imm_11, iw.j.imm_10_1, 1'b0};
            default:            imm = '0;
        endcase
    end

    always_comb begin
        alu_op = rv_core_pkg::alu_add; // addresses, lui, auipc and jumps
        if (iw.r.opcode == rv_core_pkg::opc_op || iw.r.opcode == rv_core_pkg::opc_op_imm) begin
            case (iw.r.funct3)
                3'b000: begin
                    // only the register form has a subtract
                    if (fmt == rv_core_pkg::fmt_r && iw.r.funct7[5])
                        alu_op = rv_core_pkg::alu_sub;
                end
                3'b001: alu_op = rv_core_pkg::alu_sll;
                3'b010: alu_op = rv_core_pkg::alu_slt;
                3'b011: alu_op = rv_core_pkg::alu_sltu;
                3'b100: alu_op = rv_core_pkg::alu_xor;
                3'b101: alu_op = iw.r.funct7[5] ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
                3'b110: alu_op = rv_core_pkg::alu_or;
                default: alu_op = rv_core_pkg::alu_and;
            endcase
        end
    end

    always_comb begin
        dec.opcode = iw.r.opcode;
        dec.funct3 = iw.r.funct3;
        dec.rd     = iw.r.rd;
        dec.rs1    = iw.r.rs1;
        dec.rs2    = iw.r.rs2;
        dec.imm    = imm;
        dec.fmt    = fmt;
        dec.alu_op = alu_op;
    end

endmodule

// File: reg_file.sv
/* 32 x 32-bit register file, x0 reads zero, two read ports and one write port */
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::reg_idx_t raddr1,
    input  rv_core_pkg::reg_idx_t raddr2,
    output rv_core_pkg::word_t    rdata1,
    output rv_core_pkg::word_t    rdata2,
    input  logic                  we,
    input  rv_core_pkg::reg_idx_t waddr,
    input  rv_core_pkg::word_t    wdata
);
    rv_core_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    a_x0_untouched: assert property (
        @(posedge clk) disable iff (reset) regs[0] == '0
    );

endmodule

// File: execute_unit.sv
/* operand selection, alu, branch conditions and jump target */
`timescale 1ns/1ps

module execute_unit (
    input  rv_core_pkg::decoded_t dec,
    input  rv_core_pkg::word_t    pc,
    input  rv_core_pkg::word_t    rs1_data,
    input  rv_core_pkg::word_t    rs2_data,
    output rv_core_pkg::word_t    alu_result,
    output logic                  jump_en,
    output rv_core_pkg::word_t    jump_target
);
    rv_core_pkg::word_t alu_a, alu_b;
    logic               taken;

    alu u_alu (
        .op     (dec.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    always_comb begin
        alu_a = rs1_data;
        alu_b = dec.imm;
        case (dec.fmt)
            rv_core_pkg::fmt_r: alu_b = rs2_data;
            rv_core_pkg::fmt_b,
            rv_core_pkg::fmt_j: alu_a = pc;                // target computed in the alu
            rv_core_pkg::fmt_u: alu_a = (dec.opcode == rv_core_pkg::opc_lui) ? '0 : pc;
            default: ;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        jump_target = alu_result;
        case (dec.opcode)
            rv_core_pkg::opc_jal:    jump_en = 1'b1;
            rv_core_pkg::opc_branch: jump_en = taken;
            rv_core_pkg::opc_jalr: begin
                jump_en     = 1'b1;
                jump_target = {alu_result[31:1], 1'b0}; // lsb cleared per spec
            end
            default:                 jump_en = 1'b0;
        endcase
    end

endmodule

// File: load_store_unit.sv
/* data memory request strobes and load data alignment / extension */
`timescale 1ns/1ps

module load_store_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_core_pkg::decoded_t  dec,
    input  logic                   exec_phase,
    input  rv_core_pkg::word_t     addr,
    input  rv_core_pkg::word_t     store_data,
    output rv_core_pkg::dmem_req_t dmem,
    input  rv_core_pkg::word_t     dmem_rdata,
    output rv_core_pkg::word_t     load_data,
    output logic                   mem_access
);
    logic               is_load, is_store;
    logic [2:0]         funct3_q;
    logic [1:0]         offset_q;
    rv_core_pkg::word_t shifted;

    assign is_load    = (dec.opcode == rv_core_pkg::opc_load);
    assign is_store   = (dec.opcode == rv_core_pkg::opc_store);
    assign mem_access = is_load || is_store;

    assign dmem.read  = exec_phase && is_load;
    assign dmem.write = exec_phase && is_store;
    assign dmem.addr  = {addr[31:2], 2'b00};
    assign dmem.wdata = store_data;

    // read data shows up one cycle later, keep size and lane until then
    always_ff @(posedge clk) begin
        if (exec_phase) begin
            funct3_q <= dec.funct3;
            offset_q <= addr[1:0];
        end
    end

    assign shifted = dmem_rdata >> {offset_q, 3'b000};

    always_comb begin
        case (funct3_q)
            3'b000:  load_data = {{24{shifted[7]}}, shifted[7:0]};   // lb
            3'b001:  load_data = {{16{shifted[15]}}, shifted[15:0]}; // lh
            3'b100:  load_data = {24'b0, shifted[7:0]};              // lbu
            3'b101:  load_data = {16'b0, shifted[15:0]};             // lhu
            default: load_data = dmem_rdata;                         // lw
        endcase
    end

    a_no_read_and_write: assert property (
        @(posedge clk) disable iff (reset) !(dmem.read && dmem.write)
    );

endmodule

// File: writeback_unit.sv
/* register write data and write enable per instruction kind */
`timescale 1ns/1ps

module writeback_unit (
    input  rv_core_pkg::decoded_t dec,
    input  rv_core_pkg::word_t    pc,
    input  rv_core_pkg::word_t    alu_result,
    input  rv_core_pkg::word_t    load_data,
    input  logic                  commit,
    output rv_core_pkg::word_t    wdata,
    output logic                  we
);
    logic writes_rd;

    always_comb begin
        writes_rd = 1'b1;
        case (dec.opcode)
            rv_core_pkg::opc_jal,
            rv_core_pkg::opc_jalr:   wdata = pc + 32'd4; // link address
            rv_core_pkg::opc_load:   wdata = load_data;
            rv_core_pkg::opc_op,
            rv_core_pkg::opc_op_imm,
            rv_core_pkg::opc_lui,
            rv_core_pkg::opc_auipc:  wdata = alu_result;
            default: begin
                // branches, stores and unknown opcodes
                wdata     = '0;
                writes_rd = 1'b0;
            end
        endcase
    end

    assign we = writes_rd && commit;

endmodule

// File: rv_core.sv
/* multi-cycle rv32i core top, one instruction in flight */
`timescale 1ns/1ps

module rv_core (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   imem_req,
    output rv_core_pkg::word_t     imem_addr,
    input  rv_core_pkg::word_t     imem_rdata,
    output rv_core_pkg::dmem_req_t dmem,
    input  rv_core_pkg::word_t     dmem_rdata,
    output logic                   retire_valid,
    output rv_core_pkg::retire_t   retire
);
    rv_core_pkg::word_t    pc, instr, jump_target;
    rv_core_pkg::word_t    rs1_data, rs2_data, alu_result, load_data, wb_wdata;
    rv_core_pkg::decoded_t dec;
    logic                  jump_en, mem_access, exec_phase, retire_strobe, wb_we;

    fetch_unit u_fetch (
        .clk           (clk),
        .reset         (reset),
        .jump_en       (jump_en),
        .jump_target   (jump_target),
        .mem_access    (mem_access),
        .imem_rdata    (imem_rdata),
        .imem_req      (imem_req),
        .pc            (pc),
        .instr         (instr),
        .exec_phase    (exec_phase),
        .retire_strobe (retire_strobe)
    );

    decode_unit u_decode (
        .instr (instr),
        .dec   (dec)
    );

    reg_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .we     (wb_we),
        .waddr  (dec.rd),
        .wdata  (wb_wdata)
    );

    execute_unit u_execute (
        .dec         (dec),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

    load_store_unit u_lsu (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .exec_phase (exec_phase),
        .addr       (alu_result),
        .store_data (rs2_data),
        .dmem       (dmem),
        .dmem_rdata (dmem_rdata),
        .load_data  (load_data),
        .mem_access (mem_access)
    );

    writeback_unit u_writeback (
        .dec        (dec),
        .pc         (pc),
        .alu_result (alu_result),
        .load_data  (load_data),
        .commit     (retire_strobe),
        .wdata      (wb_wdata),
        .we         (wb_we)
    );

    assign imem_addr    = pc;
    assign retire_valid = retire_strobe;

    // retire report mirrors the register file write
    assign retire.pc    = pc;
    assign retire.we    = wb_we;
    assign retire.rd    = dec.rd;
    assign retire.wdata = wb_wdata;

endmodule

// File: tb_clock_gen.sv
/* testbench clock, 8 ns period, with a synchronous reset held for two cycles */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    initial clk = 1'b0;

    always #4 clk = ~clk;

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0; // released on a rising edge
    end

endmodule

// File: rv_core_tb.sv
/* testbench for the rv32i core with memory models, program and expectation table,
   typed compare tasks and the main check loop */
`timescale 1ns/1ps

module rv_core_tb;
    typedef struct packed {
        rv_core_pkg::word_t     instr;
        rv_core_pkg::retire_t   exp;
        rv_core_pkg::dmem_req_t req;   // expected in the execute cycle
    } row_t;

    logic                   clk, reset;
    logic                   imem_req, retire_valid;
    rv_core_pkg::word_t     imem_addr;
    rv_core_pkg::word_t     imem_rdata = '0;
    rv_core_pkg::word_t     dmem_rdata = '0;
    rv_core_pkg::dmem_req_t dmem_req;
    rv_core_pkg::retire_t   retire_info;

    rv_core_pkg::word_t imem [128];
    rv_core_pkg::word_t data_mem [256];
    rv_core_pkg::word_t ref_mem [256];   // expected memory contents
    rv_core_pkg::word_t regs_ref [32];
    rv_core_pkg::word_t data_base = 32'h0001_0000;
    rv_core_pkg::word_t prog_pc;
    logic [31:0]        rng_state = 32'h3432;
    row_t               rows [$];
    int                 wait_limit = 16;

    tb_clock_gen u_clk (
        .clk   (clk),
        .reset (reset)
    );

    rv_core dut (
        .clk          (clk),
        .reset        (reset),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .dmem         (dmem_req),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire       (retire_info)
    );

    // both memories answer one cycle after the request
    always @(posedge clk) begin
        if (imem_req)
            imem_rdata <= fetch_word(imem_addr);
        if (dmem_req.read)
            dmem_rdata <= data_mem[dmem_req.addr[9:2]];
        if (dmem_req.write)
            data_mem[dmem_req.addr[9:2]] <= dmem_req.wdata;
    end

    function automatic rv_core_pkg::word_t fetch_word(input rv_core_pkg::word_t addr);
        rv_core_pkg::word_t offset;
        offset = addr - rv_core_pkg::reset_pc;
        if (offset < 32'd512)
            return imem[offset[8:2]];
        else
            return '0;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // two's complement order from the sign bits, plain order when they agree
    function automatic logic less_signed(input rv_core_pkg::word_t x,
            input rv_core_pkg::word_t y);
        if (x[31] != y[31])
            return x[31];
        return x < y;
    endfunction

    // logical shift with the vacated upper bits filled from the sign
    function automatic rv_core_pkg::word_t shift_right_arith(input rv_core_pkg::word_t x,
            input logic [4:0] n);
        rv_core_pkg::word_t fill;
        fill = x[31] ? ~(32'hffff_ffff >> n) : 32'h0;
        return (x >> n) | fill;
    endfunction

    // instruction encoders
    function automatic rv_core_pkg::word_t enc_r(input logic [6:0] f7,
            input rv_core_pkg::reg_idx_t rs2, input rv_core_pkg::reg_idx_t rs1,
            input logic [2:0] f3, input rv_core_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, rv_core_pkg::opc_op};
    endfunction

    function automatic rv_core_pkg::word_t enc_i(input logic [11:0] imm,
            input rv_core_pkg::reg_idx_t rs1, input logic [2:0] f3,
            input rv_core_pkg::reg_idx_t rd, input rv_core_pkg::opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_core_pkg::word_t enc_s(input logic [11:0] imm,
            input rv_core_pkg::reg_idx_t rs2, input rv_core_pkg::reg_idx_t rs1,
            input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_core_pkg::opc_store};
    endfunction

    function automatic rv_core_pkg::word_t enc_b(input logic [12:0] imm,
            input rv_core_pkg::reg_idx_t rs2, input rv_core_pkg::reg_idx_t rs1,
            input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_core_pkg::opc_branch};
    endfunction

    function automatic rv_core_pkg::word_t enc_u(input logic [19:0] imm,
            input rv_core_pkg::reg_idx_t rd, input rv_core_pkg::opcode_e opc);
        return {imm, rd, opc};
    endfunction

    function automatic rv_core_pkg::word_t enc_j(input logic [20:0] imm,
            input rv_core_pkg::reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_core_pkg::opc_jal};
    endfunction

    // lui half of a lui/addi pair rounded for the signed low part
    function automatic logic [19:0] upper_part(input rv_core_pkg::word_t value);
        rv_core_pkg::word_t t;
        t = value + 32'h800;
        return t[31:12];
    endfunction

    function automatic rv_core_pkg::dmem_req_t mem_req(input logic rd, input logic wr,
            input rv_core_pkg::word_t addr, input rv_core_pkg::word_t data);
        rv_core_pkg::dmem_req_t r;
        r.read  = rd;
        r.write = wr;
        r.addr  = addr;
        r.wdata = data;
        return r;
    endfunction

    function automatic rv_core_pkg::word_t load_value(input rv_core_pkg::word_t addr,
            input logic [2:0] f3);
        rv_core_pkg::word_t w;
        logic [7:0]         b;
        logic [15:0]        h;
        w = ref_mem[addr[9:2]];
        b = w[8*addr[1:0] +: 8];
        h = w[16*addr[1] +: 16];
        case (f3)
            3'b000:  return {{24{b[7]}}, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b100:  return {24'b0, b};
            3'b101:  return {16'b0, h};
            default: return w;
        endcase
    endfunction

    task automatic add_row(input rv_core_pkg::word_t instr, input logic we,
            input rv_core_pkg::reg_idx_t rd, input rv_core_pkg::word_t value,
            input rv_core_pkg::dmem_req_t req);
        row_t r;
        r.instr     = instr;
        r.exp.pc    = prog_pc;
        r.exp.we    = we;
        r.exp.rd    = rd;
        r.exp.wdata = value;
        r.req       = req;
        rows.push_back(r);
        if (we && rd != 0)
            regs_ref[rd] = value;
        prog_pc = prog_pc + 32'd4;
    endtask

    task automatic add_reg_op(input logic [6:0] f7, input logic [2:0] f3,
            input rv_core_pkg::reg_idx_t rd, input rv_core_pkg::word_t value);
        add_row(enc_r(f7, 5'd2, 5'd1, f3, rd), 1'b1, rd, value, '0); // x1 op x2
    endtask

    task automatic add_imm_op(input logic [11:0] imm, input logic [2:0] f3,
            input rv_core_pkg::reg_idx_t rd, input rv_core_pkg::word_t value);
        add_row(enc_i(imm, 5'd1, f3, rd, rv_core_pkg::opc_op_imm), 1'b1, rd, value, '0);
    endtask

    task automatic add_load(input logic [2:0] f3, input rv_core_pkg::reg_idx_t rd,
            input logic [11:0] off);
        rv_core_pkg::word_t addr;
        addr = data_base + {20'b0, off};
        add_row(enc_i(off, 5'd10, f3, rd, rv_core_pkg::opc_load), 1'b1, rd,
                load_value(addr, f3), mem_req(1'b1, 1'b0, {addr[31:2], 2'b00}, '0));
    endtask

    task automatic add_branch(input logic [2:0] f3, input rv_core_pkg::reg_idx_t rs1,
            input rv_core_pkg::reg_idx_t rs2, input logic taken);
        rv_core_pkg::word_t here;
        here = prog_pc;
        add_row(enc_b(13'd8, rs2, rs1, f3), 1'b0, '0, '0, '0);
        if (taken)
            prog_pc = here + 32'd8; // skips one slot
    endtask

    task automatic fill_memories();
        for (int i = 0; i < 256; i++) begin
            data_mem[i] = next_random() ^ (data_base + 32'(i) * 4);
            ref_mem[i]  = data_mem[i];
        end
        for (int i = 0; i < 128; i++)
            imem[i] = '0;
        for (int i = 0; i < 32; i++)
            regs_ref[i] = '0;
    endtask

    task automatic build_program();
        rv_core_pkg::word_t a, b, imm, here;
        logic [11:0]        r12;
        logic [4:0]         sh;
        a       = next_random();
        b       = next_random();
        imm     = next_random();
        r12     = imm[11:0];
        sh      = imm[16:12];
        imm     = {{20{r12[11]}}, r12};
        prog_pc = rv_core_pkg::reset_pc;
        // random operands into x1 and x2
        add_row(enc_u(upper_part(a), 5'd1, rv_core_pkg::opc_lui), 1'b1, 5'd1,
                {upper_part(a), 12'h000}, '0);
        add_imm_op(a[11:0], 3'b000, 5'd1, a);
        add_row(enc_u(upper_part(b), 5'd2, rv_core_pkg::opc_lui), 1'b1, 5'd2,
                {upper_part(b), 12'h000}, '0);
        add_row(enc_i(b[11:0], 5'd2, 3'b000, 5'd2, rv_core_pkg::opc_op_imm), 1'b1, 5'd2, b, '0);
        add_row(enc_u(20'h12345, 5'd3, rv_core_pkg::opc_auipc), 1'b1, 5'd3,
                prog_pc + 32'h1234_5000, '0);
        add_reg_op(7'h00, 3'b000, 5'd4, a + b);
        add_reg_op(7'h20, 3'b000, 5'd5, a - b);
        add_reg_op(7'h00, 3'b001, 5'd6, a << b[4:0]);
        add_reg_op(7'h00, 3'b010, 5'd7, {31'b0, less_signed(a, b)});
        add_reg_op(7'h00, 3'b011, 5'd8, {31'b0, a < b});
        add_reg_op(7'h00, 3'b100, 5'd9, a ^ b);
        add_reg_op(7'h00, 3'b101, 5'd10, a >> b[4:0]);
        add_reg_op(7'h20, 3'b101, 5'd11, shift_right_arith(a, b[4:0]));
        add_reg_op(7'h00, 3'b110, 5'd12, a | b);
        add_reg_op(7'h00, 3'b111, 5'd13, a & b);
        add_imm_op(r12, 3'b000, 5'd4, a + imm);
        add_imm_op(r12, 3'b010, 5'd5, {31'b0, less_signed(a, imm)});
        add_imm_op(r12, 3'b011, 5'd6, {31'b0, a < imm});
        add_imm_op(r12, 3'b100, 5'd7, a ^ imm);
        add_imm_op(r12, 3'b110, 5'd8, a | imm);
        add_imm_op(r12, 3'b111, 5'd9, a & imm);
        add_imm_op({7'h00, sh}, 3'b001, 5'd10, a << sh);
        add_imm_op({7'h00, sh}, 3'b101, 5'd11, a >> sh);
        add_imm_op({7'h20, sh}, 3'b101, 5'd12, shift_right_arith(a, sh));
        // x0 takes the write and still reads back as zero
        add_imm_op(12'd5, 3'b000, 5'd0, a + 32'd5);
        add_row(enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd14), 1'b1, 5'd14, b, '0);
        add_row(enc_u(data_base[31:12], 5'd10, rv_core_pkg::opc_lui), 1'b1, 5'd10,
                data_base, '0);
        add_row(enc_s(12'd8, 5'd1, 5'd10, 3'b010), 1'b0, '0, '0,
                mem_req(1'b0, 1'b1, data_base + 32'd8, a));
        ref_mem[2] = a;
        // sign bits set under every byte and halfword that the loads pick
        data_mem[1] = data_mem[1] | 32'h8000_8000;
        data_mem[3] = data_mem[3] | 32'h8000_8000;
        ref_mem[1]  = data_mem[1];
        ref_mem[3]  = data_mem[3];
        add_load(3'b010, 5'd15, 12'd8);
        add_load(3'b000, 5'd16, 12'd13);
        add_load(3'b001, 5'd17, 12'd14);
        add_load(3'b100, 5'd18, 12'd7);
        add_load(3'b101, 5'd19, 12'd4);
        add_branch(3'b000, 5'd1, 5'd1, 1'b1);
        add_branch(3'b001, 5'd1, 5'd1, 1'b0);
        add_branch(3'b100, 5'd1, 5'd2, less_signed(a, b));
        add_branch(3'b101, 5'd1, 5'd2, !less_signed(a, b));
        add_branch(3'b110, 5'd1, 5'd2, a < b);
        add_branch(3'b111, 5'd1, 5'd2, a >= b);
        here = prog_pc;
        add_row(enc_j(21'd12, 5'd20), 1'b1, 5'd20, here + 32'd4, '0);
        prog_pc = here + 32'd12;
        here    = prog_pc;
        add_row(enc_u(20'h0, 5'd22, rv_core_pkg::opc_auipc), 1'b1, 5'd22, here, '0);
        add_row(enc_i(12'd17, 5'd22, 3'b000, 5'd21, rv_core_pkg::opc_jalr), 1'b1, 5'd21,
                here + 32'd8, '0);
        prog_pc = here + 32'd16; // odd offset so bit 0 gets dropped
        add_row(enc_r(7'h00, 5'd21, 5'd20, 3'b000, 5'd23), 1'b1, 5'd23,
                regs_ref[20] + regs_ref[21], '0);
    endtask

    task automatic stop_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic check_addr(input string name, input rv_core_pkg::word_t got,
            input rv_core_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_dmem(input rv_core_pkg::dmem_req_t got,
            input rv_core_pkg::dmem_req_t exp);
        if (got.read !== exp.read || got.write !== exp.write ||
                ((exp.read || exp.write) && got.addr !== exp.addr) ||
                (exp.write && got.wdata !== exp.wdata)) begin
            $write("FAILED dmem: read=%h write=%h addr=%h wdata=%h",
                   got.read, got.write, got.addr, got.wdata);
            $display(", expected read=%h write=%h addr=%h wdata=%h",
                     exp.read, exp.write, exp.addr, exp.wdata);
            stop_run();
        end
    endtask

    // rd and value only count when a write is reported
    task automatic check_retire(input rv_core_pkg::retire_t got,
            input rv_core_pkg::retire_t exp);
        if (got.pc !== exp.pc || got.we !== exp.we ||
                (exp.we && (got.rd !== exp.rd || got.wdata !== exp.wdata))) begin
            $write("FAILED retire: pc=%h we=%h rd=%h wdata=%h",
                   got.pc, got.we, got.rd, got.wdata);
            $display(", expected pc=%h we=%h rd=%h wdata=%h",
                     exp.pc, exp.we, exp.rd, exp.wdata);
            stop_run();
        end
    endtask

    initial begin
        int   cycles;
        int   latency;
        row_t r;
        fill_memories();
        build_program();
        foreach (rows[n])
            imem[(rows[n].exp.pc - rv_core_pkg::reset_pc) >> 2] = rows[n].instr;

        @(negedge clk);
        cycles = 0;
        while (reset) begin
            if (imem_req !== 1'b0 || retire_valid !== 1'b0 ||
                    dmem_req.read !== 1'b0 || dmem_req.write !== 1'b0)
                abort_run("a memory request or retire went high during reset");
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit)
                abort_run("reset was never released");
        end

        foreach (rows[n]) begin
            r       = rows[n];
            latency = (r.req.read || r.req.write) ? 2 : 1;
            cycles  = 0;
            while (imem_req !== 1'b1) begin
                @(negedge clk);
                cycles++;
                if (cycles > wait_limit)
                    abort_run($sformatf("no fetch request for pc %h", r.exp.pc));
            end
            // fetch comes on the cycle after reset release or after the last retire
            if (cycles != 1)
                abort_run($sformatf("fetch for pc %h came after %0d cycles, not 1",
                                    r.exp.pc, cycles));
            check_addr("imem_addr", imem_addr, r.exp.pc);
            @(negedge clk); // execute cycle
            check_dmem(dmem_req, r.req);
            cycles = 1;
            while (retire_valid !== 1'b1) begin
                @(negedge clk);
                cycles++;
                if (cycles > wait_limit)
                    abort_run($sformatf("instruction at pc %h never retired", r.exp.pc));
            end
            if (cycles != latency)
                abort_run($sformatf("instruction at pc %h retired after %0d cycles, not %0d",
                                    r.exp.pc, cycles, latency));
            check_retire(retire_info, r.exp);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// File: rv_core.f
rv_core_pkg.sv
alu.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
execute_unit.sv
load_store_unit.sv
writeback_unit.sv
rv_core.sv
tb_clock_gen.sv
rv_core_tb.sv
